//--- rtl/board_pkg.sv
// Shared widths for the arcade board input section
// Button positions in the board joystick word and the host status field map

package board_pkg;

    // Joystick words
    localparam int JOY_W       = 10;  // Game side field
    localparam int BOARD_JOY_W = 16;  // Board side word
    localparam int DIR_W       = 4;   // Up/down/left/right at the bottom

    // Button positions, shifted up by one when the game uses three buttons
    localparam int START1_BASE = 6;
    localparam int START2_BASE = 7;
    localparam int COIN_BASE   = 8;
    localparam int PAUSE_BASE  = 9;

    // Host status word
    localparam int STATUS_W = 32;

    localparam int ST_ROTATE_BIT = 2;  // Also drives rot_control
    localparam int ST_FLIP_BIT   = 3;
    localparam int ST_TEST_BIT   = 4;
    localparam int ST_PAUSE_BIT  = 5;  // Pause requested from the OSD
    localparam int ST_FX_LSB     = 6;  // Two bit FX level
    localparam int ST_NOFM_BIT   = 8;
    localparam int ST_NOPSG_BIT  = 9;

endpackage

//--- rtl/reset_gen.sv
// Game reset generator with retriggerable counter
// Four-phase rst_req/rst_ack handshake and delayed active low game reset

module reset_gen #(
    parameter logic [7:0] GAME_RST_LEN = 8'd16
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic dip_flip,
    input  logic rst_req,
    output logic rst_ack,
    output logic game_rst,
    output logic game_rst_n
);

    logic       last_dip_flip;
    logic [7:0] rst_cnt;
    logic       req_busy;    // Request taken, reset still running
    logic       pre_rst_n;
    logic       flip_chg;
    logic       req_accept;
    logic       trigger;

    assign flip_chg   = last_dip_flip != dip_flip;
    assign req_accept = rst_req & ~rst_ack & ~req_busy;  // Only from the idle phase
    assign trigger    = rst | downloading | flip_chg | req_accept;

    // Counter restarts on every trigger
    always_ff @(posedge clk_sys) begin
        last_dip_flip <= dip_flip;
        if (trigger) begin
            rst_cnt  <= 8'd0;
            game_rst <= 1'b1;
        end else if (rst_cnt != GAME_RST_LEN - 8'd1) begin
            rst_cnt <= rst_cnt + 8'd1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // Handshake with the host
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            req_busy <= 1'b0;
            rst_ack  <= 1'b0;
        end else begin
            if (req_accept) begin
                req_busy <= 1'b1;
            end else if (req_busy && !game_rst && rst_req) begin
                req_busy <= 1'b0;  // Reset done, acknowledge
                rst_ack  <= 1'b1;
            end else if (req_busy && !rst_req) begin
                req_busy <= 1'b0;  // Host gave up early
            end
            if (rst_ack && !rst_req)
                rst_ack <= 1'b0;
        end
    end

    // Trigger term keeps game_rst_n low on the same edge game_rst rises
    always_ff @(posedge clk_sys) begin
        if (trigger || game_rst) begin
            pre_rst_n  <= 1'b0;
            game_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            game_rst_n <= pre_rst_n;
        end
    end

endmodule

//--- rtl/dip_decode.sv
// Host status word register and DIP/OSD field decode

module dip_decode (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  logic [board_pkg::STATUS_W-1:0] status,
    input  logic                          game_pause,
    output logic                          rot_control,
    output logic [1:0]                    rotate,
    output logic                          dip_flip,
    output logic                          dip_test,
    output logic                          dip_pause,
    output logic [1:0]                    dip_fxlevel,
    output logic                          enable_fm,
    output logic                          enable_psg
);

    import board_pkg::*;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rot_control <= 1'b0;
            rotate      <= 2'b00;
            dip_flip    <= 1'b0;
            dip_test    <= 1'b0;
            dip_pause   <= 1'b1;  // Running
            dip_fxlevel <= 2'd0;
            enable_fm   <= 1'b1;
            enable_psg  <= 1'b1;
        end else begin
            rot_control <= status[ST_ROTATE_BIT];
            rotate      <= {status[ST_FLIP_BIT], status[ST_ROTATE_BIT]};
            dip_flip    <= status[ST_FLIP_BIT];
            dip_test    <= status[ST_TEST_BIT];
            // Active low, either pause source stops the game
            dip_pause   <= ~(game_pause | status[ST_PAUSE_BIT]);
            dip_fxlevel <= status[ST_FX_LSB +: 2];
            enable_fm   <= ~status[ST_NOFM_BIT];
            enable_psg  <= ~status[ST_NOPSG_BIT];
        end
    end

endmodule

//--- rtl/input_capture.sv
// Joystick input pipeline, stages 1 and 2
// Board word sync, button extraction and pause edge detect

module input_capture #(
    parameter int THREE_BUTTONS = 0
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    output logic [board_pkg::JOY_W-1:0]       cap_joy1,
    output logic [board_pkg::JOY_W-1:0]       cap_joy2,
    output logic [1:0]                        cap_coin,
    output logic [1:0]                        cap_start,
    output logic                              pause_edge
);

    import board_pkg::*;

    localparam int START1_BIT = START1_BASE + THREE_BUTTONS;
    localparam int START2_BIT = START2_BASE + THREE_BUTTONS;
    localparam int COIN_BIT   = COIN_BASE + THREE_BUTTONS;
    localparam int PAUSE_BIT  = PAUSE_BASE + THREE_BUTTONS;

    logic [BOARD_JOY_W-1:0] joy1_sync;
    logic [BOARD_JOY_W-1:0] joy2_sync;
    logic                   joy_pause;
    logic                   last_pause;

    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    // Stage 1
    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    // Stage 2 payload
    always_ff @(posedge clk_sys) begin
        cap_joy1  <= joy1_sync[JOY_W-1:0];
        cap_joy2  <= joy2_sync[JOY_W-1:0];
        cap_coin  <= {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]};
        cap_start <= {joy1_sync[START2_BIT] | joy2_sync[START2_BIT],
                      joy1_sync[START1_BIT] | joy2_sync[START1_BIT]};
    end

    // Stage 2 pause edge, one pulse per press
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause <= 1'b0;
            pause_edge <= 1'b0;
        end else begin
            last_pause <= joy_pause;
            pause_edge <= joy_pause & ~last_pause;
        end
    end

endmodule

//--- rtl/input_map.sv
// Joystick input pipeline, stage 3
// Rotation, polarity, game output register and pause toggle

module input_map #(
    parameter logic INPUTS_ACTIVE_LOW = 1'b1
) (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic [board_pkg::JOY_W-1:0] cap_joy1,
    input  logic [board_pkg::JOY_W-1:0] cap_joy2,
    input  logic [1:0]                  cap_coin,
    input  logic [1:0]                  cap_start,
    input  logic                        pause_edge,
    input  logic                        rot_control,
    output logic [board_pkg::JOY_W-1:0] game_joystick1,
    output logic [board_pkg::JOY_W-1:0] game_joystick2,
    output logic [1:0]                  game_coin,
    output logic [1:0]                  game_start,
    output logic                        game_service,
    output logic                        game_pause
);

    import board_pkg::*;

    logic [JOY_W-1:0] joy1_rot;
    logic [JOY_W-1:0] joy2_rot;

    // Swap bits 0/1 and 2/3 for a rotated screen
    function automatic logic [JOY_W-1:0] rotate_dirs(input logic [JOY_W-1:0] joy,
                                                     input logic rot);
        logic [JOY_W-1:0] swapped;
        swapped = {joy[JOY_W-1:DIR_W], joy[2], joy[3], joy[0], joy[1]};
        return rot ? swapped : joy;
    endfunction

    assign joy1_rot = rotate_dirs(cap_joy1, rot_control);
    assign joy2_rot = rotate_dirs(cap_joy2, rot_control);

    // No service source left on this board
    assign game_service = INPUTS_ACTIVE_LOW;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {JOY_W{INPUTS_ACTIVE_LOW}};  // Idle level
            game_joystick2 <= {JOY_W{INPUTS_ACTIVE_LOW}};
            game_coin      <= {2{INPUTS_ACTIVE_LOW}};
            game_start     <= {2{INPUTS_ACTIVE_LOW}};
            game_pause     <= 1'b0;
        end else begin
            game_joystick1 <= {JOY_W{INPUTS_ACTIVE_LOW}} ^ joy1_rot;
            game_joystick2 <= {JOY_W{INPUTS_ACTIVE_LOW}} ^ joy2_rot;
            game_coin      <= {2{INPUTS_ACTIVE_LOW}} ^ cap_coin;
            game_start     <= {2{INPUTS_ACTIVE_LOW}} ^ cap_start;
            if (pause_edge)
                game_pause <= ~game_pause;
        end
    end

endmodule

//--- rtl/board_top.sv
// Board input and reset section top level
// Reset generator, DIP decode and the three stage joystick pipeline

module board_top #(
    parameter int         THREE_BUTTONS     = 0,
    parameter logic       INPUTS_ACTIVE_LOW = 1'b1,
    parameter logic [7:0] GAME_RST_LEN      = 8'd16
) (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic                             downloading,
    input  logic                             rst_req,
    input  logic [board_pkg::STATUS_W-1:0]    status,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [board_pkg::BOARD_JOY_W-1:0] board_joystick2,
    output logic                              rst_ack,
    output logic                              game_rst,
    output logic                              game_rst_n,
    output logic [board_pkg::JOY_W-1:0]       game_joystick1,
    output logic [board_pkg::JOY_W-1:0]       game_joystick2,
    output logic [1:0]                        game_coin,
    output logic [1:0]                        game_start,
    output logic                              game_service,
    output logic                              game_pause,
    output logic [1:0]                        rotate,
    output logic                              dip_flip,
    output logic                              dip_test,
    output logic                              dip_pause,
    output logic [1:0]                        dip_fxlevel,
    output logic                              enable_fm,
    output logic                              enable_psg
);

    logic [board_pkg::JOY_W-1:0] cap_joy1;
    logic [board_pkg::JOY_W-1:0] cap_joy2;
    logic [1:0]                  cap_coin;
    logic [1:0]                  cap_start;
    logic                        pause_edge;
    logic                        rot_control;

    reset_gen #(
        .GAME_RST_LEN(GAME_RST_LEN)
    ) u_reset_gen (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .downloading(downloading),
        .dip_flip   (dip_flip),     // Flip change restarts the game
        .rst_req    (rst_req),
        .rst_ack    (rst_ack),
        .game_rst   (game_rst),
        .game_rst_n (game_rst_n)
    );

    dip_decode u_dip_decode (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .status     (status),
        .game_pause (game_pause),
        .rot_control(rot_control),
        .rotate     (rotate),
        .dip_flip   (dip_flip),
        .dip_test   (dip_test),
        .dip_pause  (dip_pause),
        .dip_fxlevel(dip_fxlevel),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg)
    );

    input_capture #(
        .THREE_BUTTONS(THREE_BUTTONS)
    ) u_input_capture (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .board_joystick1(board_joystick1),
        .board_joystick2(board_joystick2),
        .cap_joy1       (cap_joy1),
        .cap_joy2       (cap_joy2),
        .cap_coin       (cap_coin),
        .cap_start      (cap_start),
        .pause_edge     (pause_edge)
    );

    input_map #(
        .INPUTS_ACTIVE_LOW(INPUTS_ACTIVE_LOW)
    ) u_input_map (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .cap_joy1      (cap_joy1),
        .cap_joy2      (cap_joy2),
        .cap_coin      (cap_coin),
        .cap_start     (cap_start),
        .pause_edge    (pause_edge),
        .rot_control   (rot_control),
        .game_joystick1(game_joystick1),
        .game_joystick2(game_joystick2),
        .game_coin     (game_coin),
        .game_start    (game_start),
        .game_service  (game_service),
        .game_pause    (game_pause)
    );

endmodule

//--- tests/board_chk.sv
// Concurrent assertions on the reset generator
// Handshake order and game reset polarity, bound into reset_gen

module board_chk (
    input logic clk_sys,
    input logic rst,
    input logic rst_req,
    input logic rst_ack,
    input logic game_rst,
    input logic game_rst_n
);

    // Acknowledge only ever answers a pending request
    ack_after_req: assert property (@(posedge clk_sys) disable iff (rst)
        $rose(rst_ack) |-> $past(rst_req))
        else $error("rst_ack rose while rst_req was low");

    rst_polarity: assert property (@(posedge clk_sys) disable iff (rst)
        game_rst |-> !game_rst_n)
        else $error("game_rst_n high while game_rst is high");

endmodule

bind reset_gen board_chk u_board_chk (
    .clk_sys   (clk_sys),
    .rst       (rst),
    .rst_req   (rst_req),
    .rst_ack   (rst_ack),
    .game_rst  (game_rst),
    .game_rst_n(game_rst_n)
);

//--- tests/board_check.sv
// Pipeline checker, queues expected game outputs and compares
// them with the DUT after the fixed three cycle latency

module board_check (
    input  logic                        clk_sys,
    input  logic                        check_en,
    input  logic [23:0]                 exp_word,  // {joy1, joy2, coin, start}
    input  logic [board_pkg::JOY_W-1:0] game_joystick1,
    input  logic [board_pkg::JOY_W-1:0] game_joystick2,
    input  logic [1:0]                  game_coin,
    input  logic [1:0]                  game_start,
    input  logic                        game_service,
    input  logic                        idle_level,
    output int                          errors,
    output int                          compared
);

    import board_pkg::*;

    logic [24:0] pending[$];  // {valid, expected}
    logic [24:0] head;
    int          err_cnt = 0;
    int          cmp_cnt = 0;

    assign errors   = err_cnt;
    assign compared = cmp_cnt;

    task automatic compare_field(input string name, input logic [9:0] got,
                                 input logic [9:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    always @(posedge clk_sys) begin
        if (pending.size() == 3) begin
            head = pending.pop_front();
            if (head[24]) begin
                cmp_cnt++;
                compare_field("game_joystick1", game_joystick1, head[23:14]);
                compare_field("game_joystick2", game_joystick2, head[13:4]);
                compare_field("game_coin", 10'(game_coin), 10'(head[3:2]));
                compare_field("game_start", 10'(game_start), 10'(head[1:0]));
                compare_field("game_service", 10'(game_service), 10'(idle_level));
            end
        end
        pending.push_back({check_en, exp_word});  // Word sampled this edge
    end

endmodule

//--- tests/board_tb.sv
// Testbench for the board input and reset section
// Clock, reset, LCG stimulus, reference model and test sequence

module board_tb;

    import board_pkg::*;

    localparam int         PERIOD        = 8;
    localparam int         WAIT_MAX      = 200;
    localparam int         THREE_BUTTONS = 0;
    localparam logic       ACTIVE_LOW    = 1'b1;
    localparam logic [7:0] RST_LEN       = 8'd16;

    logic                   clk_sys = 1'b0;
    logic                   rst;
    logic                   downloading;
    logic                   rst_req;
    logic [STATUS_W-1:0]    status;
    logic [BOARD_JOY_W-1:0] board_joystick1;
    logic [BOARD_JOY_W-1:0] board_joystick2;
    logic                   rst_ack;
    logic                   game_rst;
    logic                   game_rst_n;
    logic [JOY_W-1:0]       game_joystick1;
    logic [JOY_W-1:0]       game_joystick2;
    logic [1:0]             game_coin;
    logic [1:0]             game_start;
    logic                   game_service;
    logic                   game_pause;
    logic [1:0]             rotate;
    logic                   dip_flip;
    logic                   dip_test;
    logic                   dip_pause;
    logic [1:0]             dip_fxlevel;
    logic                   enable_fm;
    logic                   enable_psg;

    logic        check_en;
    logic [23:0] exp_word;
    logic        rot;                   // Rotation the reference applies
    logic [31:0] lcg_state = 32'h7172;
    logic        p;
    int          tb_errors = 0;
    int          chk_errors;
    int          chk_compared;
    int          test_num = 0;
    int          err_mark = 0;
    int          n;

    board_top #(
        .THREE_BUTTONS    (THREE_BUTTONS),
        .INPUTS_ACTIVE_LOW(ACTIVE_LOW),
        .GAME_RST_LEN     (RST_LEN)
    ) uut (.*);

    board_check u_check (
        .clk_sys       (clk_sys),
        .check_en      (check_en),
        .exp_word      (exp_word),
        .game_joystick1(game_joystick1),
        .game_joystick2(game_joystick2),
        .game_coin     (game_coin),
        .game_start    (game_start),
        .game_service  (game_service),
        .idle_level    (ACTIVE_LOW),
        .errors        (chk_errors),
        .compared      (chk_compared)
    );

    always #(PERIOD / 2) clk_sys = ~clk_sys;

    task automatic next_cycle();
        @(posedge clk_sys);
        #1;  // Drive point
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Game side view of a board word pair, {joy1, joy2, coin, start}
    function automatic logic [23:0] expect_inputs(input logic [15:0] j1, input logic [15:0] j2,
                                                  input logic rot_on, input logic pol);
        logic [JOY_W-1:0] e1;
        logic [JOY_W-1:0] e2;
        logic [1:0]       coin;
        logic [1:0]       start;
        e1 = j1[JOY_W-1:0];
        e2 = j2[JOY_W-1:0];
        if (rot_on) begin
            e1[3:0] = {j1[2], j1[3], j1[0], j1[1]};
            e2[3:0] = {j2[2], j2[3], j2[0], j2[1]};
        end
        coin  = {j2[COIN_BASE + THREE_BUTTONS], j1[COIN_BASE + THREE_BUTTONS]};
        start = {j1[START2_BASE + THREE_BUTTONS] | j2[START2_BASE + THREE_BUTTONS],
                 j1[START1_BASE + THREE_BUTTONS] | j2[START1_BASE + THREE_BUTTONS]};
        return {e1, e2, coin, start} ^ {24{pol}};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    // Cycles until game_rst reaches a level
    task automatic wait_game_rst(input logic level, output int cycles);
        cycles = 0;
        while (game_rst !== level && cycles < WAIT_MAX) begin
            next_cycle();
            cycles++;
        end
        if (game_rst !== level) begin
            $display("timeout: game_rst never reached %0d", level);
            tb_errors++;
        end
    endtask

    task automatic run_random(input int cycles);
        check_en = 1'b1;
        repeat (cycles) begin
            lcg_state = lcg_next(lcg_state);
            board_joystick1 = lcg_state[31:16];
            lcg_state = lcg_next(lcg_state);
            board_joystick2 = lcg_state[31:16];
            exp_word = expect_inputs(board_joystick1, board_joystick2, rot, ACTIVE_LOW);
            next_cycle();
        end
        check_en = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        repeat (4) next_cycle();  // Drain the pipeline
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = tb_errors + chk_errors - err_mark;
        test_num++;
        $display("test %0d %s: %s", test_num, name, errs == 0 ? "ok" : "errors");
        err_mark = tb_errors + chk_errors;
    endtask

    initial begin
        rst = 1'b1;
        downloading = 1'b0;
        rst_req = 1'b0;
        status = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        check_en = 1'b0;
        exp_word = '0;
        rot = 1'b0;
        repeat (3) @(posedge clk_sys);
        #1 rst = 1'b0;

        check_eq("rst_ack", 32'(rst_ack), 32'd0);
        check_eq("game_rst", 32'(game_rst), 32'd1);
        check_eq("game_pause", 32'(game_pause), 32'd0);
        check_eq("game_joystick1", 32'(game_joystick1), 32'({JOY_W{ACTIVE_LOW}}));
        check_eq("game_joystick2", 32'(game_joystick2), 32'({JOY_W{ACTIVE_LOW}}));
        check_eq("game_coin", 32'(game_coin), 32'({2{ACTIVE_LOW}}));
        check_eq("game_start", 32'(game_start), 32'({2{ACTIVE_LOW}}));
        check_eq("game_service", 32'(game_service), 32'(ACTIVE_LOW));
        end_test("reset state");

        run_random(40);
        status[ST_ROTATE_BIT] = 1'b1;
        rot = 1'b1;
        repeat (4) next_cycle();
        run_random(40);
        if (chk_compared == 0) begin
            $display("no pipeline words were compared");
            tb_errors++;
        end
        end_test("joystick pipeline");

        p = game_pause;
        board_joystick1[PAUSE_BASE + THREE_BUTTONS] = 1'b1;
        repeat (3) next_cycle();
        check_eq("game_pause", 32'(game_pause), 32'(!p));
        repeat (6) next_cycle();  // Still held
        check_eq("game_pause", 32'(game_pause), 32'(!p));
        check_eq("dip_pause", 32'(dip_pause), 32'(p));
        board_joystick1 = '0;
        repeat (3) next_cycle();
        board_joystick2[PAUSE_BASE + THREE_BUTTONS] = 1'b1;
        repeat (3) next_cycle();
        check_eq("game_pause", 32'(game_pause), 32'(p));
        status[ST_PAUSE_BIT] = 1'b1;
        next_cycle();
        check_eq("dip_pause", 32'(dip_pause), 32'd0);
        status[ST_PAUSE_BIT] = 1'b0;
        board_joystick2 = '0;
        repeat (2) next_cycle();
        check_eq("dip_pause", 32'(dip_pause), 32'(!p));
        end_test("pause toggle");

        wait_game_rst(1'b0, n);
        rst_req = 1'b1;
        wait_game_rst(1'b1, n);
        wait_game_rst(1'b0, n);
        check_eq("game_rst length", 32'(n), 32'(RST_LEN));
        check_eq("rst_ack", 32'(rst_ack), 32'd0);
        next_cycle();
        check_eq("rst_ack", 32'(rst_ack), 32'd1);
        check_eq("game_rst_n", 32'(game_rst_n), 32'd0);
        next_cycle();
        check_eq("game_rst_n", 32'(game_rst_n), 32'd1);
        rst_req = 1'b0;
        next_cycle();
        check_eq("rst_ack", 32'(rst_ack), 32'd0);
        end_test("reset handshake");

        status = '0;
        status[ST_FLIP_BIT] = 1'b1;
        status[ST_TEST_BIT] = 1'b1;
        status[ST_FX_LSB +: 2] = 2'b10;
        status[ST_NOFM_BIT] = 1'b1;
        next_cycle();
        check_eq("rotate", 32'(rotate), 32'h2);
        check_eq("dip_flip", 32'(dip_flip), 32'd1);
        check_eq("dip_test", 32'(dip_test), 32'd1);
        check_eq("dip_fxlevel", 32'(dip_fxlevel), 32'h2);
        check_eq("enable_fm", 32'(enable_fm), 32'd0);
        check_eq("enable_psg", 32'(enable_psg), 32'd1);
        wait_game_rst(1'b1, n);
        wait_game_rst(1'b0, n);
        check_eq("game_rst length", 32'(n), 32'(RST_LEN));
        end_test("flip and status decode");

        $display("tests %0d, pipeline compares %0d, errors %0d",
                 test_num, chk_compared, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
rtl/board_pkg.sv
rtl/reset_gen.sv
rtl/dip_decode.sv
rtl/input_capture.sv
rtl/input_map.sv
rtl/board_top.sv
tests/board_chk.sv
tests/board_check.sv
tests/board_tb.sv

//--- Makefile
SIM        := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
TOP        := board_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log

SHELL := /bin/bash

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q '\*\*\* FAILED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
